/* ex_pkg.sv */
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DIV_STEPS  = 32;  // One quotient bit per step
    localparam int STEP_CNT_W = 6;   // Must hold DIV_STEPS

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_SLTU = 4'd6,
        OP_SLL  = 4'd7,
        OP_SRL  = 4'd8,
        OP_SRA  = 4'd9,
        OP_DIV  = 4'd10,  // Signed quotient
        OP_DIVU = 4'd11,
        OP_MOD  = 4'd12,  // Signed remainder
        OP_MODU = 4'd13
    } alu_op_t;

endpackage

/* div_if.sv */
`timescale 1ns/1ps

interface div_if;
    import ex_pkg::*;

    logic  start;      // One-cycle load pulse
    data_t dividend;
    data_t divisor;
    logic  is_signed;
    logic  want_rem;   // Remainder is the result to write back
    data_t quotient;
    data_t remainder;

    modport ctrl (
        output start, dividend, divisor, is_signed, want_rem,
        input  quotient, remainder
    );

    modport unit (
        input  start, dividend, divisor, is_signed, want_rem,
        output quotient, remainder
    );

endinterface

/* issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_req,
    input  ex_pkg::alu_op_t op,
    input  logic            step_last,
    output logic            capture,
    output logic            div_start,
    output logic            wb_load,
    output logic            in_ack
);
    import ex_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        EXEC,      // Writeback cycle for both paths
        DIV_RUN,
        ACK_HOLD,
        RELEASE
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   is_div;

    assign is_div = (op == OP_DIV) || (op == OP_DIVU) || (op == OP_MOD) || (op == OP_MODU);

    assign capture   = (state == IDLE) && in_req;
    assign div_start = capture && is_div;  // Divider loads on the capture edge
    assign wb_load   = (state == EXEC);
    assign in_ack    = (state == ACK_HOLD);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_req) begin
                    state_nxt = is_div ? DIV_RUN : EXEC;
                end
            end
            EXEC:     state_nxt = ACK_HOLD;
            DIV_RUN:  state_nxt = step_last ? EXEC : DIV_RUN;
            ACK_HOLD: state_nxt = in_req ? ACK_HOLD : RELEASE;  // Wait for req to drop
            RELEASE:  state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Four-phase rule seen from the requester side
    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset) $rose(in_ack) |-> in_req
    );

endmodule

/* div_counter.sv */
`timescale 1ns/1ps

module div_counter (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic step_en,
    output logic step_last
);
    import ex_pkg::*;

    logic [STEP_CNT_W-1:0] cnt;  // Steps left, zero when idle

    assign step_en   = (cnt != '0);
    assign step_last = (cnt == STEP_CNT_W'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= STEP_CNT_W'(DIV_STEPS);
        end else if (step_en) begin
            cnt <= cnt - 1'b1;
        end
    end

    // A new divide must wait for the previous one to finish
    no_restart: assert property (
        @(posedge clk) disable iff (reset) start |-> !step_en
    );

endmodule

/* operand_stage.sv */
`timescale 1ns/1ps

module operand_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              capture,
    input  ex_pkg::alu_op_t   op,
    input  ex_pkg::reg_addr_t rs1_addr,
    input  ex_pkg::reg_addr_t rs2_addr,
    input  ex_pkg::data_t     rs1_data,
    input  ex_pkg::data_t     rs2_data,
    input  ex_pkg::reg_addr_t rd_addr,
    input  logic              rd_we,
    input  logic              fwd_we,
    input  ex_pkg::reg_addr_t fwd_addr,
    input  ex_pkg::data_t     fwd_data,
    output ex_pkg::alu_op_t   lat_op,
    output ex_pkg::reg_addr_t lat_rd,
    output logic              lat_we,
    output ex_pkg::data_t     src1,
    output ex_pkg::data_t     src2,
    div_if.ctrl               div
);
    import ex_pkg::*;

    data_t   src1_fwd;
    data_t   src2_fwd;
    alu_op_t cur_op;

    // Register 0 is never forwarded
    assign src1_fwd = (fwd_we && rs1_addr == fwd_addr && rs1_addr != '0) ? fwd_data : rs1_data;
    assign src2_fwd = (fwd_we && rs2_addr == fwd_addr && rs2_addr != '0) ? fwd_data : rs2_data;

    always_ff @(posedge clk) begin
        if (capture) begin
            lat_op <= op;
            lat_rd <= rd_addr;
            src1   <= src1_fwd;
            src2   <= src2_fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lat_we <= 1'b0;
        end else if (capture) begin
            lat_we <= rd_we;
        end
    end

    // Divider loads on the capture edge, so it sees the live values then
    assign cur_op        = capture ? op : lat_op;
    assign div.dividend  = capture ? src1_fwd : src1;
    assign div.divisor   = capture ? src2_fwd : src2;
    assign div.is_signed = (cur_op == OP_DIV) || (cur_op == OP_MOD);
    assign div.want_rem  = (cur_op == OP_MOD) || (cur_op == OP_MODU);

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  ex_pkg::alu_op_t op,
    input  ex_pkg::data_t   a,
    input  ex_pkg::data_t   b,
    output ex_pkg::data_t   result
);
    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            OP_SRA:  result = data_t'($signed(a) >>> shamt);  // Sign fill
            default: result = '0;  // Divide ops come from the divider
        endcase
    end

endmodule

/* divider.sv */
`timescale 1ns/1ps

module divider (
    input  logic clk,
    input  logic reset,
    input  logic step_en,
    div_if.unit  div
);
    import ex_pkg::*;

    data_t         quo;       // Dividend shifts out, quotient bits shift in
    data_t         rem;       // Partial remainder, always below dvs
    data_t         dvs;
    logic          neg_q;
    logic          neg_r;
    logic          sign_a;
    logic          sign_b;
    data_t         mag_a;
    data_t         mag_b;
    logic [XLEN:0] diff;

    assign sign_a = div.is_signed && div.dividend[XLEN-1];
    assign sign_b = div.is_signed && div.divisor[XLEN-1];
    assign mag_a  = sign_a ? -div.dividend : div.dividend;
    assign mag_b  = sign_b ? -div.divisor : div.divisor;

    assign diff = {rem, quo[XLEN-1]} - {1'b0, dvs};  // Top bit set means restore

    // Only the result that gets written back needs its sign fixed
    always_ff @(posedge clk) begin
        if (reset) begin
            neg_q <= 1'b0;
            neg_r <= 1'b0;
        end else if (div.start) begin
            neg_q <= (sign_a ^ sign_b) && !div.want_rem;
            neg_r <= sign_a && div.want_rem;
        end
    end

    always_ff @(posedge clk) begin
        if (div.start) begin
            quo <= mag_a;
            rem <= '0;
            dvs <= mag_b;
        end else if (step_en) begin
            if (!diff[XLEN]) begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= {rem[XLEN-2:0], quo[XLEN-1]};
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
    end

    assign div.quotient  = neg_q ? -quo : quo;
    assign div.remainder = neg_r ? -rem : rem;  // Follows the dividend sign

    nonzero_divisor: assert property (
        @(posedge clk) disable iff (reset) div.start |-> (div.divisor != '0)
    );

endmodule

/* wb_reg.sv */
`timescale 1ns/1ps

module wb_reg (
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_load,
    input  ex_pkg::alu_op_t   lat_op,
    input  ex_pkg::reg_addr_t lat_rd,
    input  logic              lat_we,
    input  ex_pkg::data_t     alu_result,
    div_if.ctrl               div,
    output logic              wb_valid,
    output logic              wb_we,
    output ex_pkg::reg_addr_t wb_addr,
    output ex_pkg::data_t     wb_data
);
    import ex_pkg::*;

    data_t result;

    always_comb begin
        case (lat_op)
            OP_DIV, OP_DIVU: result = div.quotient;
            OP_MOD, OP_MODU: result = div.remainder;
            default:         result = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_load) begin
            wb_addr <= lat_rd;
            wb_data <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= wb_load;  // One-cycle pulse
            if (wb_load) begin
                wb_we <= lat_we;  // Held for forwarding
            end
        end
    end

endmodule

/* ex_wb_stage.sv */
`timescale 1ns/1ps

module ex_wb_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_req,
    output logic              in_ack,
    input  ex_pkg::alu_op_t   op,
    input  ex_pkg::reg_addr_t rs1_addr,
    input  ex_pkg::reg_addr_t rs2_addr,
    input  ex_pkg::data_t     rs1_data,
    input  ex_pkg::data_t     rs2_data,
    input  ex_pkg::reg_addr_t rd_addr,
    input  logic              rd_we,
    output logic              wb_valid,
    output logic              wb_we,
    output ex_pkg::reg_addr_t wb_addr,
    output ex_pkg::data_t     wb_data
);
    import ex_pkg::*;

    logic      capture;
    logic      wb_load;
    logic      step_en;
    logic      step_last;
    alu_op_t   lat_op;
    reg_addr_t lat_rd;
    logic      lat_we;
    data_t     src1;
    data_t     src2;
    data_t     alu_result;

    div_if div_bus ();

    issue_ctrl u_issue_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_req    (in_req),
        .op        (op),
        .step_last (step_last),
        .capture   (capture),
        .div_start (div_bus.start),
        .wb_load   (wb_load),
        .in_ack    (in_ack)
    );

    div_counter u_div_counter (
        .clk       (clk),
        .reset     (reset),
        .start     (div_bus.start),
        .step_en   (step_en),
        .step_last (step_last)
    );

    operand_stage u_operand_stage (
        .clk      (clk),
        .reset    (reset),
        .capture  (capture),
        .op       (op),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_addr  (rd_addr),
        .rd_we    (rd_we),
        .fwd_we   (wb_we),     // Last writeback feeds forwarding
        .fwd_addr (wb_addr),
        .fwd_data (wb_data),
        .lat_op   (lat_op),
        .lat_rd   (lat_rd),
        .lat_we   (lat_we),
        .src1     (src1),
        .src2     (src2),
        .div      (div_bus.ctrl)
    );

    alu u_alu (
        .op     (lat_op),
        .a      (src1),
        .b      (src2),
        .result (alu_result)
    );

    divider u_divider (
        .clk     (clk),
        .reset   (reset),
        .step_en (step_en),
        .div     (div_bus.unit)
    );

    wb_reg u_wb_reg (
        .clk        (clk),
        .reset      (reset),
        .wb_load    (wb_load),
        .lat_op     (lat_op),
        .lat_rd     (lat_rd),
        .lat_we     (lat_we),
        .alu_result (alu_result),
        .div        (div_bus.ctrl),
        .wb_valid   (wb_valid),
        .wb_we      (wb_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

endmodule

/* tb_ex_wb.sv */
`timescale 1ns/1ps

module tb_ex_wb;
    import ex_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_RANDOM   = 300;
    localparam int N_DIRECTED = 21;
    localparam int N_TOTAL    = N_RANDOM + N_DIRECTED;
    localparam int ALU_EDGES  = 2;
    localparam int DIV_EDGES  = 34;  // Capture, 32 steps, writeback

    typedef struct packed {
        data_t     data;
        reg_addr_t addr;
        logic      we;
    } wb_exp_t;

    logic      clk;
    logic      reset;
    logic      in_req;
    logic      in_ack;
    alu_op_t   op;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1_data;
    data_t     rs2_data;
    reg_addr_t rd_addr;
    logic      rd_we;
    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_addr;
    data_t     wb_data;

    logic [31:0] rng_state = 32'd45;
    data_t       regs [32];   // True register state
    data_t       stale [32];  // Register file view lagging one writeback
    logic        pend_we;
    reg_addr_t   pend_addr;
    data_t       pend_data;
    wb_exp_t     exp_q [$];
    int          data_errors = 0;
    int          proto_errors = 0;
    int          checks = 0;

    ex_wb_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int pick_below(input int n);
        logic [31:0] w;
        w = rand_word();
        return int'(w >> 8) % n;  // Low LCG bits are weak
    endfunction

    function automatic logic takes_divider(input alu_op_t o);
        return (o == OP_DIV) || (o == OP_DIVU) || (o == OP_MOD) || (o == OP_MODU);
    endfunction

    function automatic data_t ref_result(input alu_op_t o, input data_t a, input data_t b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   ovf;
        sa  = a;
        sb  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);  // MIN / -1
        case (o)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return (sa < sb) ? data_t'(1) : '0;
            OP_SLTU: return (a < b) ? data_t'(1) : '0;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return data_t'(sa >>> b[4:0]);
            OP_DIV:  return ovf ? a : data_t'(sa / sb);
            OP_DIVU: return a / b;
            OP_MOD:  return ovf ? '0 : data_t'(sa % sb);
            OP_MODU: return a % b;
            default: return '0;
        endcase
    endfunction

    task automatic run_instr(input alu_op_t o, input reg_addr_t s1, input reg_addr_t s2,
                             input reg_addr_t rd, input logic we);
        wb_exp_t e;
        int      edges;
        int      exp_edges;
        int      hold;
        e.data    = ref_result(o, regs[s1], regs[s2]);
        e.addr    = rd;
        e.we      = we;
        exp_edges = takes_divider(o) ? DIV_EDGES : ALU_EDGES;
        exp_q.push_back(e);
        @(posedge clk);
        in_req   <= 1'b1;
        op       <= o;
        rs1_addr <= s1;
        rs2_addr <= s2;
        rs1_data <= stale[s1];  // Stale unless forwarding fixes it
        rs2_data <= stale[s2];
        rd_addr  <= rd;
        rd_we    <= we;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (!wb_valid) begin
                assert (!in_ack) else begin  // Ack comes with the writeback
                    proto_errors++;
                    $display("error at %0t: in_ack expected 0 got %b", $time, in_ack);
                end
            end
        end while (!wb_valid && edges < 2 * DIV_EDGES);
        assert (wb_valid) else begin
            proto_errors++;
            $display("No writeback for the request at %0t", $time);
        end
        assert (edges == exp_edges) else begin
            proto_errors++;
            $display("error at %0t: latency expected %0d got %0d", $time, exp_edges, edges);
        end
        assert (in_ack) else begin
            proto_errors++;
            $display("error at %0t: in_ack expected 1 got %b", $time, in_ack);
        end
        hold = pick_below(4);
        repeat (hold) begin  // Back-pressure from the requester
            @(posedge clk);
            @(negedge clk);
            assert (in_ack) else begin
                proto_errors++;
                $display("error at %0t: in_ack expected 1 got %b", $time, in_ack);
            end
        end
        @(posedge clk);
        in_req <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (!in_ack) else begin
            proto_errors++;
            $display("error at %0t: in_ack expected 0 got %b", $time, in_ack);
        end
        if (pend_we) begin
            stale[pend_addr] = pend_data;
        end
        pend_we   = we && (rd != '0);
        pend_addr = rd;
        pend_data = e.data;
        if (pend_we) begin
            regs[rd] = e.data;
        end
    endtask

    task automatic divide_cases(input data_t x, input data_t y);
        regs[30]  = x;
        stale[30] = x;
        regs[31]  = y;
        stale[31] = y;
        run_instr(OP_DIV, 5'd30, 5'd31, 5'd29, 1'b1);
        run_instr(OP_DIVU, 5'd30, 5'd31, 5'd29, 1'b1);
        run_instr(OP_MOD, 5'd30, 5'd31, 5'd29, 1'b1);
        run_instr(OP_MODU, 5'd30, 5'd31, 5'd29, 1'b1);
    endtask

    always @(negedge clk) begin
        wb_exp_t e;
        if (!reset && wb_valid) begin
            assert (exp_q.size() > 0) else begin
                data_errors++;
                $display("Unexpected writeback at %0t with no request outstanding", $time);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                checks++;
                assert (wb_data === e.data) else begin
                    data_errors++;
                    $display("error at %0t: wb_data expected %h got %h", $time, e.data, wb_data);
                end
                assert (wb_addr === e.addr) else begin
                    data_errors++;
                    $display("error at %0t: wb_addr expected %0d got %0d", $time, e.addr, wb_addr);
                end
                assert (wb_we === e.we) else begin
                    data_errors++;
                    $display("error at %0t: wb_we expected %b got %b", $time, e.we, wb_we);
                end
            end
        end
    end

    initial begin
        #(N_TOTAL * 40 * CLK_PERIOD);
        $display("Watchdog expired at %0t before all instructions finished", $time);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        alu_op_t   o;
        reg_addr_t s1;
        reg_addr_t s2;
        reg_addr_t rd;
        reg_addr_t last_rd;
        logic      we;
        reset    = 1'b1;
        in_req   = 1'b0;
        op       = OP_ADD;
        rs1_addr = '0;
        rs2_addr = '0;
        rs1_data = '0;
        rs2_data = '0;
        rd_addr  = '0;
        rd_we    = 1'b0;
        pend_we  = 1'b0;
        pend_addr = '0;
        pend_data = '0;
        last_rd  = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i]  = (i == 0) ? '0 : (rand_word() ^ data_t'(i));
            stale[i] = regs[i];
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!in_ack) else begin
            proto_errors++;
            $display("error at %0t: in_ack expected 0 got %b", $time, in_ack);
        end
        assert (!wb_valid) else begin
            proto_errors++;
            $display("error at %0t: wb_valid expected 0 got %b", $time, wb_valid);
        end
        assert (!wb_we) else begin
            proto_errors++;
            $display("error at %0t: wb_we expected 0 got %b", $time, wb_we);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            o  = alu_op_t'(4'(pick_below(14)));
            s1 = (pick_below(2) == 0) ? last_rd : reg_addr_t'(pick_below(32));  // Dependent
            s2 = (pick_below(3) == 0) ? last_rd : reg_addr_t'(pick_below(32));
            rd = reg_addr_t'(pick_below(32));
            we = (pick_below(5) != 0);
            if (takes_divider(o) && regs[s2] == '0) begin
                o = OP_OR;  // Never divide by zero
            end
            last_rd = rd;
            run_instr(o, s1, s2, rd, we);
        end
        run_instr(OP_ADD, 5'd1, 5'd2, 5'd3, 1'b0);  // Clears the forwarding source
        divide_cases(32'hffff_fff9, 32'd2);
        divide_cases(32'd7, 32'hffff_fffe);
        divide_cases(32'hffff_fff9, 32'hffff_fffe);
        divide_cases(32'h8000_0000, 32'hffff_ffff);
        divide_cases(32'hffff_ffff, 32'd3);
        repeat (4) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            data_errors++;
            $display("%0d expected writebacks never arrived", exp_q.size());
        end
        $display("Checks %0d, data errors %0d, protocol errors %0d",
                 checks, data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* vlog.f */
ex_pkg.sv
div_if.sv
issue_ctrl.sv
div_counter.sv
operand_stage.sv
alu.sv
divider.sv
wb_reg.sv
ex_wb_stage.sv
tb_ex_wb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_wb
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
